// ==== rca_lsq_top.f ====
source/lsq_cfg_pkg.sv
source/lsq_types_pkg.sv
source/lsq_packet_queue.sv
source/lsq_bus_master.sv
source/lsq_load_return.sv
source/rca_lsq_top.sv
tb/rca_lsq_sva.sv
tb/rca_lsq_tb.sv

// ==== Bender.yml ====
package:
  name: rca_lsq

sources:
  - source/lsq_cfg_pkg.sv
  - source/lsq_types_pkg.sv
  - source/lsq_packet_queue.sv
  - source/lsq_bus_master.sv
  - source/lsq_load_return.sv
  - source/rca_lsq_top.sv
  - target: test
    files:
      - tb/rca_lsq_sva.sv
      - tb/rca_lsq_tb.sv

// ==== tb/rca_lsq_tb.sv ====
`timescale 1ns/1ps

module rca_lsq_tb;
    import lsq_cfg_pkg::*;
    import lsq_types_pkg::*;

    localparam int NROWS     = 4;
    localparam int QDEPTH    = 4;
    localparam int MEM_WORDS = 64;
    localparam int TIMEOUT   = 400;

    // One grid packet where row r uses bit or slice r of each field
    typedef struct packed {
        logic [NROWS-1:0]           req;
        logic [NROWS-1:0]           st;
        logic [NROWS-1:0][XLEN-1:0] a;
        logic [NROWS-1:0][XLEN-1:0] d;
        mem_width_e [NROWS-1:0]     w;
    } packet_t;

    typedef struct packed {
        logic [XLEN-1:0]   adr;
        logic [XLEN/8-1:0] sel;
        logic              we;
    } bus_exp_t;

    typedef struct packed {
        logic [1:0]      row;
        logic [XLEN-1:0] value;
    } load_t;

    logic                 clk;
    logic                 rst_n;
    logic [NROWS-1:0]     new_request;
    logic [XLEN-1:0]      addr [NROWS];
    logic [XLEN-1:0]      wdata [NROWS];
    mem_width_e           width [NROWS];
    logic                 load [NROWS];
    logic                 store [NROWS];
    logic                 rca_busy;
    logic                 grid_full;
    logic                 lsu_lock;
    logic [NROWS-1:0]     load_complete;
    logic [XLEN-1:0]      load_data;
    logic                 wb_cyc;
    logic                 wb_stb;
    logic                 wb_we;
    logic [XLEN-1:0]      wb_adr;
    logic [XLEN-1:0]      wb_dat_w;
    logic [XLEN/8-1:0]    wb_sel;
    logic [XLEN-1:0]      wb_dat_r;
    logic                 wb_ack;

    packet_t              stim_tab[$];
    bus_exp_t             exp_bus[$];
    load_t                exp_load[$];
    load_t                got_load[$];
    logic [XLEN-1:0]      mem [MEM_WORDS];
    logic [XLEN-1:0]      ref_mem [MEM_WORDS];
    int                   errors;
    int                   seed;
    int                   wait_cnt;
    logic                 hold_ack;

    rca_lsq_top #(
        .NUM_ROWS   (NROWS),
        .QUEUE_DEPTH(QDEPTH)
    ) dut_i (
        .clk, .rst_n, .new_request, .addr, .wdata, .width, .load, .store,
        .rca_busy, .grid_full, .lsu_lock, .load_complete, .load_data,
        .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_sel, .wb_dat_r, .wb_ack
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Wishbone slave with random wait states and a one-cycle ack
    always @(negedge clk) begin
        if (wb_ack) begin
            wb_ack = 1'b0;
        end else if (wb_cyc && wb_stb && !hold_ack) begin
            if (wait_cnt > 0) begin
                wait_cnt--;
            end else begin
                if (wb_we) begin
                    for (int b = 0; b < XLEN / 8; b++) begin
                        if (wb_sel[b]) begin
                            mem[wb_adr[7:2]][8*b +: 8] = wb_dat_w[8*b +: 8];
                        end
                    end
                end
                wb_dat_r = mem[wb_adr[7:2]];
                wb_ack   = 1'b1;
                wait_cnt = $random(seed) & 3;
            end
        end
    end

    // Bus and load monitors
    always @(posedge clk) begin
        if (wb_stb && wb_ack) begin
            if (exp_bus.size() == 0) begin
                errors++;
                $display("unexpected bus transaction at address %h", wb_adr);
            end else begin
                check_bus(exp_bus.pop_front());
            end
        end
        if (load_complete != '0) begin
            if (!$onehot(load_complete)) begin
                errors++;
                $display("more than one row got a load result at once");
            end
            for (int r = 0; r < NROWS; r++) begin
                if (load_complete[r]) begin
                    got_load.push_back({2'(r), load_data});
                end
            end
        end
    end

    task automatic give_up(input string what);
        $display("timeout while waiting for %s", what);
        $display("errors: %0d", errors);
        $display("=== FAIL ===");
        $finish;
    endtask

    task automatic check_bus(input bus_exp_t e);
        if (wb_adr !== e.adr || wb_sel !== e.sel || wb_we !== e.we) begin
            errors++;
            $display("error wb_adr/wb_sel/wb_we exp %h/%h/%h got %h/%h/%h",
                     e.adr, e.sel, e.we, wb_adr, wb_sel, wb_we);
        end
    endtask

    task automatic check_load(input logic [1:0] row, input logic [XLEN-1:0] value);
        load_t g;
        int    n;
        n = 0;
        while (got_load.size() == 0) begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT) give_up("load_complete");
        end
        g = got_load.pop_front();
        if (g.row !== row || g.value !== value) begin
            errors++;
            $display("error load_complete row/load_data exp %h/%h got %h/%h",
                     row, value, g.row, g.value);
        end
    endtask

    task automatic check_flag(input logic full_exp, input logic lock_exp);
        if (grid_full !== full_exp) begin
            errors++;
            $display("error grid_full exp %h got %h", full_exp, grid_full);
        end
        if (lsu_lock !== lock_exp) begin
            errors++;
            $display("error lsu_lock exp %h got %h", lock_exp, lsu_lock);
        end
    endtask

    function automatic packet_t with_row(packet_t p, int r, logic st, logic [XLEN-1:0] a,
                                         mem_width_e w, logic [XLEN-1:0] d);
        p.req[r] = 1'b1;
        p.st[r]  = st;
        p.a[r]   = a;
        p.w[r]   = w;
        p.d[r]   = d;
        return p;
    endfunction

    // Reference model handling rows lowest first
    task automatic predict(input packet_t p);
        logic [XLEN-1:0]   word;
        logic [XLEN-1:0]   sh;
        logic [XLEN/8-1:0] sel;
        logic [1:0]        off;
        int                idx;
        for (int r = 0; r < NROWS; r++) begin
            if (p.req[r]) begin
                off = p.a[r][1:0];
                idx = p.a[r][7:2];
                case (p.w[r])
                    width_b, width_bu: sel = 4'b0001 << off;
                    width_h, width_hu: sel = 4'b0011 << (off[1] * 2);
                    default:           sel = 4'b1111;
                endcase
                exp_bus.push_back({p.a[r] & ~32'h3, sel, p.st[r]});
                if (p.st[r]) begin
                    case (p.w[r])
                        width_b: ref_mem[idx][8*off +: 8] = p.d[r][7:0];
                        width_h: ref_mem[idx][16*off[1] +: 16] = p.d[r][15:0];
                        default: ref_mem[idx] = p.d[r];
                    endcase
                end else begin
                    sh = ref_mem[idx] >> (8 * off);
                    case (p.w[r])
                        width_b:  word = {{24{sh[7]}}, sh[7:0]};
                        width_bu: word = {24'h0, sh[7:0]};
                        width_h:  word = {{16{sh[15]}}, sh[15:0]};
                        width_hu: word = {16'h0, sh[15:0]};
                        default:  word = sh;
                    endcase
                    exp_load.push_back({2'(r), word});
                end
            end
        end
    endtask

    task automatic apply_packet(input packet_t p);
        int n;
        n = 0;
        while (grid_full) begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT) give_up("grid_full to fall");
        end
        for (int r = 0; r < NROWS; r++) begin
            addr[r]  = p.a[r];
            wdata[r] = p.d[r];
            width[r] = p.w[r];
            load[r]  = p.req[r] && !p.st[r];
            store[r] = p.req[r] && p.st[r];
        end
        new_request = p.req;
        predict(p);
        @(negedge clk);
        new_request = '0;
    endtask

    // Wait for an empty queue and idle bus, then compare every load result
    task automatic drain_and_verify();
        int n;
        n = 0;
        while (lsu_lock || wb_cyc || exp_bus.size() != 0) begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT * 8) give_up("the queue to drain");
        end
        while (exp_load.size() != 0) begin
            check_load(exp_load[0].row, exp_load[0].value);
            void'(exp_load.pop_front());
        end
        repeat (3) @(negedge clk);
        if (got_load.size() != 0) begin
            errors++;
            $display("load results arrived that no request asked for");
            got_load.delete();
        end
    endtask

    task automatic build_directed();
        packet_t p;
        p = '0;
        stim_tab.push_back(with_row(p, 1, 1, 32'h10, width_w, 32'hcafe_f00d));
        stim_tab.push_back(with_row(p, 2, 0, 32'h10, width_w, 0));
        p = with_row('0, 0, 1, 32'h21, width_b, 32'ha5);
        p = with_row(p, 1, 1, 32'h26, width_h, 32'h8001);
        p = with_row(p, 2, 0, 32'h20, width_w, 0);
        stim_tab.push_back(with_row(p, 3, 0, 32'h21, width_b, 0));
        p = with_row('0, 0, 0, 32'h21, width_bu, 0);
        p = with_row(p, 1, 0, 32'h26, width_h, 0);
        p = with_row(p, 2, 0, 32'h26, width_hu, 0);
        stim_tab.push_back(with_row(p, 3, 0, 32'h20, width_b, 0));
        p = with_row('0, 0, 0, 32'h22, width_b, 0);
        p = with_row(p, 1, 0, 32'h23, width_bu, 0);
        p = with_row(p, 2, 0, 32'h24, width_h, 0);
        stim_tab.push_back(with_row(p, 3, 0, 32'h20, width_hu, 0));
        // Every row requests and is served lowest row first
        p = with_row('0, 0, 1, 32'h30, width_w, 32'h1122_3344);
        p = with_row(p, 1, 1, 32'h34, width_h, 32'hbeef);
        p = with_row(p, 2, 1, 32'h37, width_b, 32'h80);
        stim_tab.push_back(with_row(p, 3, 0, 32'h34, width_w, 0));
        p = with_row('0, 0, 0, 32'h37, width_b, 0);
        p = with_row(p, 1, 0, 32'h37, width_bu, 0);
        p = with_row(p, 2, 0, 32'h32, width_hu, 0);
        stim_tab.push_back(with_row(p, 3, 0, 32'h36, width_h, 0));
    endtask

    function automatic packet_t random_packet();
        packet_t         p;
        mem_width_e      w;
        logic            st;
        logic [XLEN-1:0] a;
        p = '0;
        for (int r = 0; r < NROWS; r++) begin
            if ($random(seed) & 1) begin
                st = $random(seed) & 1;
                case ($unsigned($random(seed)) % 5)
                    0:       w = width_b;
                    1:       w = width_h;
                    2:       w = width_w;
                    3:       w = st ? width_b : width_bu;
                    default: w = st ? width_h : width_hu;
                endcase
                a = 32'h40 + ($random(seed) & 32'h3c);
                if (w == width_b || w == width_bu) a = a + ($random(seed) & 3);
                if (w == width_h || w == width_hu) a = a + (($random(seed) & 1) * 2);
                p = with_row(p, r, st, a, w, $random(seed));
            end
        end
        return p;
    endfunction

    initial begin
        seed        = 32'he8c3_540f;
        errors      = 0;
        wait_cnt    = 0;
        hold_ack    = 1'b0;
        rst_n       = 1'b0;
        rca_busy    = 1'b0;
        new_request = '0;
        wb_ack      = 1'b0;
        wb_dat_r    = '0;
        for (int r = 0; r < NROWS; r++) begin
            addr[r]  = '0;
            wdata[r] = '0;
            width[r] = width_w;
            load[r]  = 1'b0;
            store[r] = 1'b0;
        end
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i]     = {8'(i), ~8'(i), 8'(i) ^ 8'h5a, 8'hc3 + 8'(i)};
            ref_mem[i] = mem[i];
        end
        repeat (8) @(negedge clk);
        rst_n = 1'b1;

        if (wb_cyc || wb_stb || load_complete != '0) begin
            errors++;
            $display("bus cycle or load strobe active right after reset");
        end
        check_flag(1'b0, 1'b0);
        rca_busy = 1'b1;
        @(negedge clk);
        check_flag(1'b0, 1'b1);
        rca_busy = 1'b0;
        @(negedge clk);

        build_directed();
        foreach (stim_tab[i]) begin
            apply_packet(stim_tab[i]);
            drain_and_verify();
        end

        // A packet without requests is not stored and never reaches the bus
        apply_packet('0);
        check_flag(1'b0, 1'b0);
        drain_and_verify();

        // With ack withheld two rows per packet keep each one in the ring
        hold_ack = 1'b1;
        for (int k = 0; k < QDEPTH; k++) begin
            apply_packet(with_row(with_row('0, 0, 1, 32'h50 + 8 * k, width_w, 32'h7100 + k),
                                  2, 0, 32'h50 + 8 * k, width_w, 0));
        end
        check_flag(1'b1, 1'b1);
        repeat (5) @(negedge clk);
        check_flag(1'b1, 1'b1);
        hold_ack = 1'b0;
        drain_and_verify();

        repeat (16) apply_packet(random_packet());
        drain_and_verify();

        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== tb/rca_lsq_sva.sv ====
`timescale 1ns/1ps

module lsq_bus_sva (
    input logic                            clk,
    input logic                            rst_n,
    input lsq_types_pkg::bus_state_e       state,
    input logic                            wb_cyc,
    input logic                            wb_stb,
    input logic                            wb_ack,
    input logic [lsq_cfg_pkg::XLEN-1:0]    wb_adr
);
    import lsq_types_pkg::*;

    stb_needs_cyc: assert property (@(posedge clk) disable iff (!rst_n)
        wb_stb |-> wb_cyc)
        else $error("wb_stb high without wb_cyc");

    // Address held until the slave acks
    adr_stable: assert property (@(posedge clk) disable iff (!rst_n)
        wb_stb && !wb_ack |=> wb_stb && $stable(wb_adr))
        else $error("wb_adr or wb_stb changed before wb_ack");

    no_cyc_in_reset: assert property (@(posedge clk)
        !rst_n |=> !wb_cyc)
        else $error("wb_cyc high during reset");

    // Cycle closes on ack and the FSM passes through done
    ack_ends_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        wb_cyc && wb_ack |=> !wb_cyc && state == bus_done)
        else $error("wb_cyc still high after wb_ack");

endmodule

bind lsq_bus_master lsq_bus_sva sva_i (
    .clk, .rst_n, .state, .wb_cyc, .wb_stb, .wb_ack, .wb_adr
);

// ==== source/rca_lsq_top.sv ====
`timescale 1ns/1ps

module rca_lsq_top #(
    parameter int NUM_ROWS    = lsq_cfg_pkg::DEF_NUM_ROWS,
    parameter int QUEUE_DEPTH = lsq_cfg_pkg::DEF_QUEUE_DEPTH
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic [NUM_ROWS-1:0]            new_request,
    input  logic [lsq_cfg_pkg::XLEN-1:0]   addr [NUM_ROWS],
    input  logic [lsq_cfg_pkg::XLEN-1:0]   wdata [NUM_ROWS],
    input  lsq_types_pkg::mem_width_e      width [NUM_ROWS],
    input  logic                           load [NUM_ROWS],
    input  logic                           store [NUM_ROWS],
    input  logic                           rca_busy,
    output logic                           grid_full,
    output logic                           lsu_lock,
    output logic [NUM_ROWS-1:0]            load_complete,
    output logic [lsq_cfg_pkg::XLEN-1:0]   load_data,
    output logic                           wb_cyc,
    output logic                           wb_stb,
    output logic                           wb_we,
    output logic [lsq_cfg_pkg::XLEN-1:0]   wb_adr,
    output logic [lsq_cfg_pkg::XLEN-1:0]   wb_dat_w,
    output logic [lsq_cfg_pkg::XLEN/8-1:0] wb_sel,
    input  logic [lsq_cfg_pkg::XLEN-1:0]   wb_dat_r,
    input  logic                           wb_ack
);
    import lsq_cfg_pkg::*;
    import lsq_types_pkg::*;

    logic                        req_valid;
    logic                        req_ready;
    logic [XLEN-1:0]             req_addr;
    logic [XLEN-1:0]             req_wdata;
    mem_width_e                  req_width;
    logic                        req_we;
    logic [$clog2(NUM_ROWS)-1:0] req_row;
    logic                        load_done;
    logic [XLEN-1:0]             load_raw;

    lsq_packet_queue #(
        .NUM_ROWS   (NUM_ROWS),
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) queue_i (
        .clk, .rst_n, .new_request, .addr, .wdata, .width, .load, .store,
        .rca_busy, .req_ready, .grid_full, .lsu_lock, .req_valid,
        .req_addr, .req_wdata, .req_width, .req_we, .req_row
    );

    lsq_bus_master master_i (
        .clk, .rst_n, .req_valid, .req_addr, .req_wdata, .req_width, .req_we,
        .wb_dat_r, .wb_ack, .req_ready, .wb_cyc, .wb_stb, .wb_we, .wb_adr,
        .wb_dat_w, .wb_sel, .load_done, .load_raw
    );

    // Snoops the queue handshake to learn each load's row
    lsq_load_return #(
        .NUM_ROWS(NUM_ROWS)
    ) return_i (
        .clk, .rst_n, .req_valid, .req_ready, .req_we, .req_row, .req_width,
        .req_addr, .load_done, .load_raw, .load_complete, .load_data
    );

endmodule

// ==== source/lsq_load_return.sv ====
`timescale 1ns/1ps

module lsq_load_return #(
    parameter int NUM_ROWS = lsq_cfg_pkg::DEF_NUM_ROWS
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          req_valid,
    input  logic                          req_ready,
    input  logic                          req_we,
    input  logic [$clog2(NUM_ROWS)-1:0]   req_row,
    input  lsq_types_pkg::mem_width_e     req_width,
    input  logic [lsq_cfg_pkg::XLEN-1:0]  req_addr,
    input  logic                          load_done,
    input  logic [lsq_cfg_pkg::XLEN-1:0]  load_raw,
    output logic [NUM_ROWS-1:0]           load_complete,
    output logic [lsq_cfg_pkg::XLEN-1:0]  load_data
);
    import lsq_cfg_pkg::*;
    import lsq_types_pkg::*;

    localparam int ROW_W = $clog2(NUM_ROWS);
    localparam int OFF_W = $clog2(XLEN / 8);

    // Destination of the single outstanding load
    logic [ROW_W-1:0] dest_row;
    mem_width_e       dest_width;
    logic [OFF_W-1:0] dest_off;

    logic [XLEN-1:0]  shifted;
    logic [XLEN-1:0]  extended;

    always_ff @(posedge clk) begin
        if (req_valid && req_ready && !req_we) begin
            dest_row   <= req_row;
            dest_width <= req_width;
            dest_off   <= req_addr[OFF_W-1:0];
        end
    end

    // Addressed lane down to bit 0
    assign shifted = load_raw >> {dest_off, 3'b000};

    always_comb begin
        case (dest_width)
            width_b:  extended = {{(XLEN-8){shifted[7]}}, shifted[7:0]};
            width_bu: extended = {{(XLEN-8){1'b0}}, shifted[7:0]};
            width_h:  extended = {{(XLEN-16){shifted[15]}}, shifted[15:0]};
            width_hu: extended = {{(XLEN-16){1'b0}}, shifted[15:0]};
            default:  extended = load_raw;
        endcase
    end

    always_ff @(posedge clk) begin
        if (load_done) begin
            load_data <= extended;
        end
    end

    // One-hot strobe towards the requesting row
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            load_complete <= '0;
        end else begin
            for (int i = 0; i < NUM_ROWS; i++) begin
                load_complete[i] <= load_done && (dest_row == ROW_W'(i));
            end
        end
    end

endmodule

// ==== source/lsq_bus_master.sv ====
`timescale 1ns/1ps

module lsq_bus_master (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           req_valid,
    input  logic [lsq_cfg_pkg::XLEN-1:0]   req_addr,
    input  logic [lsq_cfg_pkg::XLEN-1:0]   req_wdata,
    input  lsq_types_pkg::mem_width_e      req_width,
    input  logic                           req_we,
    input  logic [lsq_cfg_pkg::XLEN-1:0]   wb_dat_r,
    input  logic                           wb_ack,
    output logic                           req_ready,
    output logic                           wb_cyc,
    output logic                           wb_stb,
    output logic                           wb_we,
    output logic [lsq_cfg_pkg::XLEN-1:0]   wb_adr,
    output logic [lsq_cfg_pkg::XLEN-1:0]   wb_dat_w,
    output logic [lsq_cfg_pkg::XLEN/8-1:0] wb_sel,
    output logic                           load_done,
    output logic [lsq_cfg_pkg::XLEN-1:0]   load_raw
);
    import lsq_cfg_pkg::*;
    import lsq_types_pkg::*;

    localparam int SEL_W = XLEN / 8;

    bus_state_e      state;
    logic [XLEN-1:0] addr_q;
    logic [XLEN-1:0] wdata_q;
    mem_width_e      width_q;
    logic            we_q;

    // Idle and done both take a new request
    assign req_ready = (state != bus_active);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= bus_idle;
        end else begin
            case (state)
                bus_idle, bus_done: state <= req_valid ? bus_active : bus_idle;
                bus_active:         state <= wb_ack ? bus_done : bus_active;
                default:            state <= bus_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid && req_ready) begin
            addr_q  <= req_addr;
            wdata_q <= req_wdata;
            width_q <= req_width;
            we_q    <= req_we;
        end
        if (wb_cyc && wb_ack) begin
            load_raw <= wb_dat_r;
        end
    end

    assign wb_cyc = (state == bus_active);
    assign wb_stb = (state == bus_active);
    assign wb_we  = wb_cyc && we_q;
    assign wb_adr = {addr_q[XLEN-1:2], 2'b00};

    // Lane enables from width and byte offset
    always_comb begin
        case (width_q)
            width_b, width_bu: wb_sel = SEL_W'(1) << addr_q[1:0];
            width_h, width_hu: wb_sel = SEL_W'(3) << {addr_q[1], 1'b0};
            default:           wb_sel = '1;
        endcase
    end

    // Narrow store data copied into every lane
    always_comb begin
        case (width_q)
            width_b: wb_dat_w = {(XLEN/8){wdata_q[7:0]}};
            width_h: wb_dat_w = {(XLEN/16){wdata_q[15:0]}};
            default: wb_dat_w = wdata_q;
        endcase
    end

    // Read word is in load_raw during the done cycle
    assign load_done = (state == bus_done) && !we_q;

endmodule

// ==== source/lsq_packet_queue.sv ====
`timescale 1ns/1ps

module lsq_packet_queue #(
    parameter int NUM_ROWS    = lsq_cfg_pkg::DEF_NUM_ROWS,
    parameter int QUEUE_DEPTH = lsq_cfg_pkg::DEF_QUEUE_DEPTH
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [NUM_ROWS-1:0]           new_request,
    input  logic [lsq_cfg_pkg::XLEN-1:0]  addr [NUM_ROWS],
    input  logic [lsq_cfg_pkg::XLEN-1:0]  wdata [NUM_ROWS],
    input  lsq_types_pkg::mem_width_e     width [NUM_ROWS],
    input  logic                          load [NUM_ROWS],
    input  logic                          store [NUM_ROWS],
    input  logic                          rca_busy,
    input  logic                          req_ready,
    output logic                          grid_full,
    output logic                          lsu_lock,
    output logic                          req_valid,
    output logic [lsq_cfg_pkg::XLEN-1:0]  req_addr,
    output logic [lsq_cfg_pkg::XLEN-1:0]  req_wdata,
    output lsq_types_pkg::mem_width_e     req_width,
    output logic                          req_we,
    output logic [$clog2(NUM_ROWS)-1:0]   req_row
);
    import lsq_cfg_pkg::*;
    import lsq_types_pkg::*;

    localparam int PTR_W = $clog2(QUEUE_DEPTH);
    localparam int ROW_W = $clog2(NUM_ROWS);

    // Packet ring, one slot per stored packet
    logic [XLEN-1:0]     ring_addr  [QUEUE_DEPTH][NUM_ROWS];
    logic [XLEN-1:0]     ring_wdata [QUEUE_DEPTH][NUM_ROWS];
    mem_width_e          ring_width [QUEUE_DEPTH][NUM_ROWS];
    logic [NUM_ROWS-1:0] ring_store [QUEUE_DEPTH];
    logic [NUM_ROWS-1:0] ring_req   [QUEUE_DEPTH];

    logic [PTR_W-1:0]    wr_ptr;
    logic [PTR_W-1:0]    rd_ptr;
    logic [PTR_W:0]      count;

    logic [NUM_ROWS-1:0] access_mask;
    logic [NUM_ROWS-1:0] done_mask;
    logic [NUM_ROWS-1:0] pending;
    logic [ROW_W-1:0]    sel_row;
    logic                head_valid;
    logic                push;
    logic                pop;
    logic                fire;
    logic                last_row;

    // Rows without a load or store flag carry no access
    always_comb begin
        for (int i = 0; i < NUM_ROWS; i++) begin
            access_mask[i] = new_request[i] && (load[i] || store[i]);
        end
    end

    assign grid_full  = (count == (PTR_W+1)'(QUEUE_DEPTH));
    assign head_valid = (count != '0);
    assign push       = (|access_mask) && !grid_full;

    always_ff @(posedge clk) begin
        if (push) begin
            ring_req[wr_ptr] <= access_mask;
            for (int i = 0; i < NUM_ROWS; i++) begin
                ring_addr[wr_ptr][i]  <= addr[i];
                ring_wdata[wr_ptr][i] <= wdata[i];
                ring_width[wr_ptr][i] <= width[i];
                ring_store[wr_ptr][i] <= store[i];
            end
        end
    end

    // Head packet rows still waiting for the bus
    assign pending = head_valid ? (ring_req[rd_ptr] & ~done_mask) : '0;

    // Lowest pending row wins
    always_comb begin
        sel_row = '0;
        for (int i = NUM_ROWS - 1; i >= 0; i--) begin
            if (pending[i]) begin
                sel_row = ROW_W'(i);
            end
        end
    end

    assign req_valid = |pending;
    assign req_addr  = ring_addr[rd_ptr][sel_row];
    assign req_wdata = ring_wdata[rd_ptr][sel_row];
    assign req_width = ring_width[rd_ptr][sel_row];
    assign req_we    = ring_store[rd_ptr][sel_row];
    assign req_row   = sel_row;

    assign fire     = req_valid && req_ready;
    assign last_row = ((pending & ~(NUM_ROWS'(1) << sel_row)) == '0);
    assign pop      = fire && last_row;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            done_mask <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // Completed rows are forgotten once the head moves on
            if (pop) begin
                done_mask <= '0;
            end else if (fire) begin
                done_mask[sel_row] <= 1'b1;
            end
        end
    end

    // Hold off the processor LSU while work is queued or the grid runs
    assign lsu_lock = head_valid || rca_busy;

endmodule

// ==== source/lsq_types_pkg.sv ====
package lsq_types_pkg;

    // Access width, encoded as RISC-V funct3
    // Stores use only the signed codes b, h and w
    typedef enum logic [2:0] {
        width_b  = 3'b000,
        width_h  = 3'b001,
        width_w  = 3'b010,
        width_bu = 3'b100,
        width_hu = 3'b101
    } mem_width_e;

    // Wishbone master sequencing
    typedef enum logic [1:0] {
        bus_idle,
        bus_active,
        bus_done
    } bus_state_e;

endpackage

// ==== source/lsq_cfg_pkg.sv ====
package lsq_cfg_pkg;

    // Grid rows that can raise a request in the same cycle
    localparam int DEF_NUM_ROWS = 4;

    // Packets held in the ring, must be a power of two
    localparam int DEF_QUEUE_DEPTH = 4;

    // Data and address width
    localparam int XLEN = 32;

endpackage
